//--- project.f
src/tcdm_cfg_pkg.sv
src/tcdm_bus_pkg.sv
src/stream_rr_arbiter.sv
src/variable_latency_interconnect.sv
src/tcdm_bank.sv
src/tcdm_cluster.sv
test/tcdm_checker.sv
test/tcdm_tb.sv

//--- test/tcdm_tb.sv
/*
  TCDM cluster testbench
  Four initiators run phased LFSR traffic with random response
  back-pressure, the checker compares every response
*/

`timescale 1ns/1ns
`default_nettype none

module tcdm_tb;

  localparam int unsigned NumIn         = 4;
  localparam int unsigned NumOut        = 8;
  localparam int unsigned NumWords      = 64;            // Test window, 8 rows of 8 banks
  localparam int unsigned OwnWords      = NumWords / NumIn;
  localparam int unsigned SameBank      = 5;             // Bank hit by everyone in phase 2
  localparam int unsigned AliasShift    = tcdm_cfg_pkg::ByteOffWidth + $clog2(NumOut)
                                          + tcdm_cfg_pkg::AddrMemWidth;
  localparam int unsigned NumPhases     = 5;
  localparam int unsigned ReqPerIni     = 4 * OwnWords + 8 + 8 + NumWords;
  localparam int unsigned TimeoutCycles = 40 * NumIn * ReqPerIni;

  logic                                          clk_i;
  logic                                          reset_i;
  logic [NumIn-1:0]                              req_valid;
  logic [NumIn-1:0]                              req_ready;
  tcdm_bus_pkg::tcdm_req_t [NumIn-1:0]           req;
  logic [NumIn-1:0]                              resp_valid;
  logic [NumIn-1:0]                              resp_ready;
  logic [NumIn-1:0][tcdm_cfg_pkg::DataWidth-1:0] resp_rdata;
  int unsigned                                   mismatch_cnt;
  int unsigned                                   unexpected_cnt;
  int unsigned                                   pending;
  logic [15:0]                                   lfsr_state [NumIn]; // One stream per initiator
  int unsigned                                   cycle_cnt;

  tcdm_cluster #(.NumIn(NumIn), .NumOut(NumOut)) tcdm_cluster_inst (
    .clk_i (clk_i), .reset_i (reset_i),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_i (req),
    .resp_valid_o (resp_valid), .resp_ready_i (resp_ready), .resp_rdata_o (resp_rdata)
  );

  tcdm_checker #(.NumIn(NumIn), .NumOut(NumOut)) tcdm_checker_inst (
    .clk_i (clk_i), .reset_i (reset_i),
    .req_valid_i (req_valid), .req_ready_i (req_ready), .req_i (req),
    .resp_valid_i (resp_valid), .resp_ready_i (resp_ready), .resp_rdata_i (resp_rdata),
    .mismatch_cnt_o (mismatch_cnt), .unexpected_cnt_o (unexpected_cnt), .pending_o (pending)
  );

  always #4 clk_i = ~clk_i; // 8 ns period

  // Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int j, input int n);
    logic [31:0] val;
    val = '0;
    for (int b = 0; b < n; b++) begin
      val = {val[30:0], lfsr_state[j][0]};
      lfsr_state[j] = lfsr_next(lfsr_state[j]); // One step per bit
    end
    return val;
  endfunction

  // One request, then wait for its response under random ready
  task automatic do_req(input int j, input logic wen, input logic [3:0] be,
                        input logic [31:0] addr, input logic [31:0] wdata);
    logic done;
    @(negedge clk_i);
    req[j]       = '{wen: wen, be: be, addr: addr, wdata: wdata};
    req_valid[j] = 1'b1;
    do @(posedge clk_i); while (!req_ready[j]);
    @(negedge clk_i);
    req_valid[j] = 1'b0;
    done = 1'b0;
    while (!done) begin
      resp_ready[j] = (rand_bits(j, 2) != 0); // Ready three cycles in four
      @(posedge clk_i);
      done = resp_valid[j] && resp_ready[j];
      if (!done) @(negedge clk_i);
    end
  endtask

  task automatic run_phase(input int p, input int j);
    int unsigned w;
    logic [31:0] hi;
    case (p)
      0, 1: begin // Own words, full then random byte enables, read back
        for (int i = 0; i < OwnWords; i++) begin
          w = i * NumIn + j;
          do_req(j, 1'b1, (p == 0) ? 4'hF : 4'(rand_bits(j, 4)), w << 2, rand_bits(j, 32));
        end
        for (int i = 0; i < OwnWords; i++) do_req(j, 1'b0, 4'hF, (i * NumIn + j) << 2, '0);
      end
      2: begin // Everyone on one bank, owner writes while others read
        for (int r = 0; r < 8; r++) begin
          w = r * NumOut + SameBank;
          if (w % NumIn == j) do_req(j, 1'b1, 4'hF, w << 2, rand_bits(j, 32));
          else                do_req(j, 1'b0, 4'hF, w << 2, '0);
        end
      end
      3: begin // High bits above the row field alias to one word
        for (int i = 0; i < 4; i++) begin
          w  = i * NumIn + j;
          hi = rand_bits(j, 32 - AliasShift) << AliasShift;
          do_req(j, 1'b1, 4'hF, hi | (w << 2), rand_bits(j, 32));
          hi = rand_bits(j, 32 - AliasShift) << AliasShift;
          do_req(j, 1'b0, 4'hF, hi | (w << 2), '0);
        end
      end
      default: begin
        for (int v = 0; v < NumWords; v++) do_req(j, 1'b0, 4'hF, v << 2, '0); // Full sweep
      end
    endcase
  endtask

  initial begin : timeout
    cycle_cnt = 0;
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("Timeout after %0d cycles, a request or response never completed", cycle_cnt);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : main
    int unsigned total_errors;
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    req_valid  = '0;
    req        = '0;
    resp_ready = '0;
    for (int j = 0; j < NumIn; j++) begin
      lfsr_state[j] = 16'd17246;
      for (int s = 0; s < 37 * j; s++) lfsr_state[j] = lfsr_next(lfsr_state[j]); // Offset streams
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    for (int p = 0; p < NumPhases; p++) begin
      for (int j = 0; j < NumIn; j++) begin
        fork
          automatic int jj = j;
          run_phase(p, jj);
        join_none
      end
      wait fork; // Barrier between phases
    end
    @(negedge clk_i);
    total_errors = mismatch_cnt + unexpected_cnt + pending;
    if (pending != 0) $display("%0d requests never received a response", pending);
    $display("Errors: %0d mismatches, %0d unexpected responses, %0d missing responses",
             mismatch_cnt, unexpected_cnt, pending);
    if (total_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule : tcdm_tb

`default_nettype wire

//--- test/tcdm_checker.sv
/*
  TCDM cluster response checker
  Tracks every request handshake in a shadow memory and compares
  each initiator's responses against its queue of expected data
*/

`timescale 1ns/1ns
`default_nettype none

module tcdm_checker #(
  parameter int unsigned NumIn  = 4,
  parameter int unsigned NumOut = 8
) (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic [NumIn-1:0]                              req_valid_i,
  input  logic [NumIn-1:0]                              req_ready_i,
  input  tcdm_bus_pkg::tcdm_req_t [NumIn-1:0]           req_i,
  input  logic [NumIn-1:0]                              resp_valid_i,
  input  logic [NumIn-1:0]                              resp_ready_i,
  input  logic [NumIn-1:0][tcdm_cfg_pkg::DataWidth-1:0] resp_rdata_i,
  output int unsigned                                   mismatch_cnt_o,
  output int unsigned                                   unexpected_cnt_o,
  output int unsigned                                   pending_o
);

  localparam int unsigned DataWidth = tcdm_cfg_pkg::DataWidth;
  localparam int unsigned IdxBits   = $clog2(NumOut) + tcdm_cfg_pkg::AddrMemWidth;

  logic [DataWidth-1:0] shadow_mem [2**IdxBits];  // Bank index and row, high bits dropped
  logic [DataWidth-1:0] expected_q [NumIn][$];    // Oldest expectation first

  // Writes answer zero, reads the word as stored at request time
  function automatic logic [DataWidth-1:0] expected_rdata(input logic wen,
                                                          input logic [DataWidth-1:0] stored);
    return wen ? '0 : stored;
  endfunction

  function automatic logic [DataWidth-1:0] apply_byte_enables(
      input logic [DataWidth-1:0] old_word, input logic [DataWidth-1:0] wdata,
      input logic [DataWidth/8-1:0] be);
    logic [DataWidth-1:0] merged;
    merged = old_word;
    for (int b = 0; b < DataWidth / 8; b++) begin
      if (be[b]) merged[b*8 +: 8] = wdata[b*8 +: 8]; // Enabled bytes only
    end
    return merged;
  endfunction

  always @(posedge clk_i) begin : compare
    int unsigned          key;
    logic [DataWidth-1:0] expected;
    if (reset_i) begin
      mismatch_cnt_o   <= 0;
      unexpected_cnt_o <= 0;
      pending_o        <= 0;
      for (int j = 0; j < NumIn; j++) expected_q[j].delete();
    end else begin
      // Responses first, a request never answers in its own cycle
      for (int j = 0; j < NumIn; j++) begin
        if (resp_valid_i[j] && resp_ready_i[j]) begin
          if (expected_q[j].size() == 0) begin
            $display("Initiator %0d got a response at %0t with no request outstanding",
                     j, $time);
            unexpected_cnt_o = unexpected_cnt_o + 1;
          end else begin
            expected  = expected_q[j].pop_front();
            pending_o = pending_o - 1;
            if (resp_rdata_i[j] !== expected) begin
              $display("[ERROR] %0t initiator %0d rdata %h, expected %h",
                       $time, j, resp_rdata_i[j], expected);
              mismatch_cnt_o = mismatch_cnt_o + 1;
            end
          end
        end
      end
      // Request handshakes in initiator order, one per bank per cycle
      for (int j = 0; j < NumIn; j++) begin
        if (req_valid_i[j] && req_ready_i[j]) begin
          key = req_i[j].addr[tcdm_cfg_pkg::ByteOffWidth +: IdxBits];
          expected_q[j].push_back(expected_rdata(req_i[j].wen, shadow_mem[key]));
          pending_o = pending_o + 1;
          if (req_i[j].wen) begin
            shadow_mem[key] = apply_byte_enables(shadow_mem[key], req_i[j].wdata, req_i[j].be);
          end
        end
      end
    end
  end

endmodule : tcdm_checker

`default_nettype wire

//--- src/tcdm_cluster.sv
/*
  TCDM cluster top level
  Interconnect between NumIn initiators and NumOut interleaved banks
*/

`timescale 1ns/1ns
`default_nettype none

module tcdm_cluster #(
  parameter int unsigned NumIn  = 4,
  parameter int unsigned NumOut = 8
) (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  // Initiator ports
  input  logic [NumIn-1:0]                              req_valid_i,
  output logic [NumIn-1:0]                              req_ready_o,
  input  tcdm_bus_pkg::tcdm_req_t [NumIn-1:0]           req_i,
  output logic [NumIn-1:0]                              resp_valid_o,
  input  logic [NumIn-1:0]                              resp_ready_i,
  output logic [NumIn-1:0][tcdm_cfg_pkg::DataWidth-1:0] resp_rdata_o
);

  // Interconnect to bank links
  logic [NumOut-1:0]                     bank_req_valid;
  logic [NumOut-1:0]                     bank_req_ready;
  tcdm_bus_pkg::bank_req_t [NumOut-1:0]  bank_req;
  logic [NumOut-1:0]                     bank_resp_valid;
  logic [NumOut-1:0]                     bank_resp_ready;
  tcdm_bus_pkg::bank_resp_t [NumOut-1:0] bank_resp;

  variable_latency_interconnect #(
    .NumIn  (NumIn ),
    .NumOut (NumOut)
  ) interconnect_inst (
    .clk_i             (clk_i          ),
    .reset_i           (reset_i        ),
    .req_valid_i       (req_valid_i    ),
    .req_ready_o       (req_ready_o    ),
    .req_i             (req_i          ),
    .resp_valid_o      (resp_valid_o   ),
    .resp_ready_i      (resp_ready_i   ),
    .resp_rdata_o      (resp_rdata_o   ),
    .bank_req_valid_o  (bank_req_valid ),
    .bank_req_ready_i  (bank_req_ready ),
    .bank_req_o        (bank_req       ),
    .bank_resp_valid_i (bank_resp_valid),
    .bank_resp_ready_o (bank_resp_ready),
    .bank_resp_i       (bank_resp      )
  );

  // Word-interleaved banks
  for (genvar k = 0; k < NumOut; k++) begin : gen_banks
    tcdm_bank bank_inst (
      .clk_i        (clk_i             ),
      .reset_i      (reset_i           ),
      .req_valid_i  (bank_req_valid[k] ),
      .req_ready_o  (bank_req_ready[k] ),
      .req_i        (bank_req[k]       ),
      .resp_valid_o (bank_resp_valid[k]),
      .resp_ready_i (bank_resp_ready[k]),
      .resp_o       (bank_resp[k]      )
    );
  end

endmodule : tcdm_cluster

`default_nettype wire

//--- src/tcdm_bank.sv
/*
  TCDM memory bank
  Single-port word array with byte enables. Every accepted request
  pushes one entry into a two-entry response queue tagged with ini_idx
*/

`timescale 1ns/1ns
`default_nettype none

module tcdm_bank (
  input  logic                     clk_i,
  input  logic                     reset_i,
  // Request from the interconnect
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  tcdm_bus_pkg::bank_req_t  req_i,
  // Response towards the interconnect
  output logic                     resp_valid_o,
  input  logic                     resp_ready_i,
  output tcdm_bus_pkg::bank_resp_t resp_o
);

  localparam int unsigned DataWidth = tcdm_cfg_pkg::DataWidth;
  localparam int unsigned BeWidth   = tcdm_cfg_pkg::BeWidth;
  localparam int unsigned NumWords  = 2 ** tcdm_cfg_pkg::AddrMemWidth;

  logic [DataWidth-1:0]     mem_q [NumWords]; // Storage array
  tcdm_bus_pkg::bank_resp_t queue_q [2];      // Response slots
  tcdm_bus_pkg::bank_resp_t push_entry;
  logic                     wr_ptr_q;
  logic                     rd_ptr_q;
  logic [1:0]               count_q;          // Occupied slots, 0 to 2
  logic                     full;
  logic                     push;
  logic                     pop;

  assign full         = (count_q == 2'd2);
  assign resp_valid_o = (count_q != 2'd0);
  assign pop          = resp_valid_o && resp_ready_i;
  assign req_ready_o  = !full || resp_ready_i; // Slot frees up this cycle
  assign push         = req_valid_i && req_ready_o;
  assign resp_o       = queue_q[rd_ptr_q];

  // Writes answer with zero, reads with the stored word
  always_comb begin
    push_entry.ini_idx = req_i.ini_idx;
    push_entry.rdata   = req_i.wen ? '0 : mem_q[req_i.row];
  end

  // Byte-wise write port
  always_ff @(posedge clk_i) begin
    if (push && req_i.wen) begin
      for (int unsigned b = 0; b < BeWidth; b++) begin
        if (req_i.be[b]) begin
          mem_q[req_i.row][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Queue payload
  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_ptr_q] <= push_entry;
    end
  end

  // Queue control
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop)  rd_ptr_q <= ~rd_ptr_q;
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q; // Both or neither
      endcase
    end
  end

  // Occupancy never goes past the two slots
  assert property (@(posedge clk_i) disable iff (reset_i) count_q <= 2'd2)
    else $error("[tcdm_bank] response queue overflow");

endmodule : tcdm_bank

`default_nettype wire

//--- src/variable_latency_interconnect.sv
/*
  Variable latency TCDM interconnect
  Full crossbar between NumIn initiators and NumOut word-interleaved banks.
  Requests are split into bank index and row and arbitrated per bank,
  responses are arbitrated per initiator using the carried ini_idx
*/

`timescale 1ns/1ns
`default_nettype none

module variable_latency_interconnect #(
  parameter int unsigned NumIn  = 4, // Initiators, 2 to 16
  parameter int unsigned NumOut = 8  // Banks, power of 2
) (
  input  logic                                               clk_i,
  input  logic                                               reset_i,
  // Initiator side
  input  logic [NumIn-1:0]                                   req_valid_i,
  output logic [NumIn-1:0]                                   req_ready_o,
  input  tcdm_bus_pkg::tcdm_req_t [NumIn-1:0]                req_i,
  output logic [NumIn-1:0]                                   resp_valid_o,
  input  logic [NumIn-1:0]                                   resp_ready_i,
  output logic [NumIn-1:0][tcdm_cfg_pkg::DataWidth-1:0]      resp_rdata_o,
  // Bank side
  output logic [NumOut-1:0]                                  bank_req_valid_o,
  input  logic [NumOut-1:0]                                  bank_req_ready_i,
  output tcdm_bus_pkg::bank_req_t [NumOut-1:0]               bank_req_o,
  input  logic [NumOut-1:0]                                  bank_resp_valid_i,
  output logic [NumOut-1:0]                                  bank_resp_ready_o,
  input  tcdm_bus_pkg::bank_resp_t [NumOut-1:0]              bank_resp_i
);

  localparam int unsigned ByteOffWidth = tcdm_cfg_pkg::ByteOffWidth;
  localparam int unsigned AddrMemWidth = tcdm_cfg_pkg::AddrMemWidth;
  localparam int unsigned IniIdxWidth  = tcdm_cfg_pkg::IniIdxWidth;
  localparam int unsigned NumOutLog2   = $clog2(NumOut);  // Bank index bits

  logic [NumIn-1:0][NumOutLog2-1:0]      tgt_sel;    // Bank of each initiator
  tcdm_bus_pkg::bank_req_t [NumIn-1:0]   ini_req;    // Aggregated payload

  logic [NumOut-1:0][NumIn-1:0]          bank_valid; // Per-bank masked valids
  logic [NumOut-1:0][NumIn-1:0]          bank_gnt;

  logic [NumIn-1:0][NumOut-1:0]          resp_valid; // Per-initiator masked valids
  logic [NumIn-1:0][NumOut-1:0]          resp_gnt;
  tcdm_bus_pkg::bank_resp_t [NumIn-1:0]  resp_data;

  // Address split and payload aggregation
  for (genvar j = 0; j < NumIn; j++) begin : gen_inputs
    assign tgt_sel[j] = req_i[j].addr[ByteOffWidth +: NumOutLog2]; // Interleave bits
    assign ini_req[j] = '{
      wen:     req_i[j].wen,
      be:      req_i[j].be,
      row:     req_i[j].addr[ByteOffWidth + NumOutLog2 +: AddrMemWidth],
      wdata:   req_i[j].wdata,
      ini_idx: IniIdxWidth'(j)
    };
  end

  // Request crossbar, one arbiter per bank
  for (genvar k = 0; k < NumOut; k++) begin : gen_req_xbar
    for (genvar j = 0; j < NumIn; j++) begin : gen_mask
      assign bank_valid[k][j] = req_valid_i[j] && (tgt_sel[j] == NumOutLog2'(k));
    end

    stream_rr_arbiter #(
      .NumReq    (NumIn                   ),
      .payload_t (tcdm_bus_pkg::bank_req_t)
    ) req_arb_inst (
      .clk_i   (clk_i              ),
      .reset_i (reset_i            ),
      .valid_i (bank_valid[k]      ),
      .data_i  (ini_req            ),
      .ready_o (bank_gnt[k]        ),
      .valid_o (bank_req_valid_o[k]),
      .data_o  (bank_req_o[k]      ),
      .ready_i (bank_req_ready_i[k]),
      .idx_o   (                   )  // Sender already in ini_idx
    );
  end

  // Response crossbar, one arbiter per initiator
  for (genvar j = 0; j < NumIn; j++) begin : gen_resp_xbar
    for (genvar k = 0; k < NumOut; k++) begin : gen_mask
      assign resp_valid[j][k] = bank_resp_valid_i[k] &&
                                (bank_resp_i[k].ini_idx == IniIdxWidth'(j));
    end

    stream_rr_arbiter #(
      .NumReq    (NumOut                   ),
      .payload_t (tcdm_bus_pkg::bank_resp_t)
    ) resp_arb_inst (
      .clk_i   (clk_i          ),
      .reset_i (reset_i        ),
      .valid_i (resp_valid[j]  ),
      .data_i  (bank_resp_i    ),
      .ready_o (resp_gnt[j]    ),
      .valid_o (resp_valid_o[j]),
      .data_o  (resp_data[j]   ),
      .ready_i (resp_ready_i[j]),
      .idx_o   (               )  // Bank number not needed upstream
    );

    assign resp_rdata_o[j] = resp_data[j].rdata; // Tag dropped here
  end

  // Grants back to the sources, at most one arbiter grants each source
  always_comb begin
    req_ready_o       = '0;
    bank_resp_ready_o = '0;
    for (int unsigned k = 0; k < NumOut; k++) begin
      req_ready_o |= bank_gnt[k];
    end
    for (int unsigned j = 0; j < NumIn; j++) begin
      bank_resp_ready_o |= resp_gnt[j];
    end
  end

  // Elaboration checks
  if (NumIn < 2 || NumIn > 2 ** IniIdxWidth) begin : gen_chk_num_in
    $fatal(1, "[variable_latency_interconnect] NumIn does not fit the initiator tag");
  end
  if (ByteOffWidth + NumOutLog2 + AddrMemWidth > tcdm_cfg_pkg::AddrWidth) begin : gen_chk_addr
    $fatal(1, "[variable_latency_interconnect] address too narrow for the bank map");
  end
  if (NumOut < 2 || (NumOut & (NumOut - 1)) != 0) begin : gen_chk_num_out
    $fatal(1, "[variable_latency_interconnect] NumOut must be a power of 2");
  end

endmodule : variable_latency_interconnect

`default_nettype wire

//--- src/stream_rr_arbiter.sv
/*
  Round-robin stream arbiter
  Selects one of NumReq valid/ready inputs and forwards its payload.
  Grant is held on a stall, priority moves past the winner on transfer
*/

`timescale 1ns/1ns
`default_nettype none

module stream_rr_arbiter #(
  parameter int unsigned NumReq    = 4,
  parameter type         payload_t = logic,
  localparam int unsigned IdxWidth = (NumReq > 1) ? $clog2(NumReq) : 1
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  // Input streams
  input  logic     [NumReq-1:0]     valid_i,
  input  payload_t [NumReq-1:0]     data_i,
  output logic     [NumReq-1:0]     ready_o,
  // Output stream
  output logic                      valid_o,
  output payload_t                  data_o,
  input  logic                      ready_i,
  output logic     [IdxWidth-1:0]   idx_o     // Granted input
);

  logic [IdxWidth-1:0] ptr_q;  // Highest priority input
  logic [IdxWidth-1:0] sel;    // Current winner
  logic                found;

  // First valid input at or after the pointer
  always_comb begin : pick_winner
    int unsigned cand;
    sel   = ptr_q;
    found = 1'b0;
    for (int unsigned i = 0; i < NumReq; i++) begin
      cand = (ptr_q + i) % NumReq; // Wrap around
      if (!found && valid_i[cand]) begin
        sel   = IdxWidth'(cand);
        found = 1'b1;
      end
    end
  end

  assign valid_o = |valid_i;      // Independent of ready_i
  assign data_o  = data_i[sel];
  assign idx_o   = sel;

  always_comb begin
    ready_o      = '0;
    ready_o[sel] = valid_o & ready_i; // Only the winner sees ready
  end

  // Pointer update
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (valid_o) begin
      if (ready_i) begin
        // Winner served, next one gets priority
        ptr_q <= (sel == IdxWidth'(NumReq - 1)) ? '0 : sel + 1'b1;
      end else begin
        ptr_q <= sel; // Stall, winner keeps top priority
      end
    end
  end

  // At most one source sees its transfer complete
  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(ready_o))
    else $error("[stream_rr_arbiter] ready_o not one-hot");

  // Holding output stable relies on the sources keeping valid up
  assert property (@(posedge clk_i) disable iff (reset_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("[stream_rr_arbiter] payload changed during stall");

endmodule : stream_rr_arbiter

`default_nettype wire

//--- src/tcdm_bus_pkg.sv
/*
  TCDM bus payloads
  Request format on the initiator side, request and response
  formats on the bank side of the interconnect
*/

`default_nettype none

package tcdm_bus_pkg;

  // Initiator request, full byte address
  typedef struct packed {
    logic                                     wen;   // 1 = write
    logic [tcdm_cfg_pkg::BeWidth-1:0]         be;    // Byte enables
    logic [tcdm_cfg_pkg::AddrWidth-1:0]       addr;  // Byte address
    logic [tcdm_cfg_pkg::DataWidth-1:0]       wdata; // Write data
  } tcdm_req_t;

  // Request after the address split
  typedef struct packed {
    logic                                     wen;
    logic [tcdm_cfg_pkg::BeWidth-1:0]         be;
    logic [tcdm_cfg_pkg::AddrMemWidth-1:0]    row;     // Word inside the bank
    logic [tcdm_cfg_pkg::DataWidth-1:0]       wdata;
    logic [tcdm_cfg_pkg::IniIdxWidth-1:0]     ini_idx; // Sender of the request
  } bank_req_t;

  // Bank response, routed back by ini_idx
  typedef struct packed {
    logic [tcdm_cfg_pkg::DataWidth-1:0]       rdata;   // Zero for writes
    logic [tcdm_cfg_pkg::IniIdxWidth-1:0]     ini_idx;
  } bank_resp_t;

endpackage : tcdm_bus_pkg

`default_nettype wire

//--- src/tcdm_cfg_pkg.sv
/*
  TCDM cluster configuration
  Data, byte-enable and address widths plus the per-bank row depth
  shared by the interconnect and the memory banks
*/

`default_nettype none

package tcdm_cfg_pkg;

  // Data word
  localparam int unsigned DataWidth    = 32;            // Bits per word
  localparam int unsigned BeWidth      = DataWidth / 8; // One strobe per byte

  // Initiator side address
  localparam int unsigned AddrWidth    = 32;            // Byte address
  localparam int unsigned ByteOffWidth = 2;             // Byte offset inside a word

  // Bank geometry
  localparam int unsigned AddrMemWidth = 8;             // 256 words per bank

  // Tag carried through the banks so a response finds its way home
  localparam int unsigned IniIdxWidth  = 4;             // Up to 16 initiators

endpackage : tcdm_cfg_pkg

`default_nettype wire
